// ==== project.f ====
+incdir+include
verilog/cache_cmd_pkg.sv
verilog/cache_line_pkg.sv
verilog/cache_apb_front.sv
verilog/cache_req_fifo.sv
verilog/cache_mesi_engine.sv
verilog/cache_lru_ranks.sv
verilog/cache_stats.sv
verilog/cache_top.sv
tests/cache_tb.sv

// ==== Bender.yml ====
package:
  name: cache_l1_tags

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/cache_cmd_pkg.sv
      - verilog/cache_line_pkg.sv
      - verilog/cache_apb_front.sv
      - verilog/cache_req_fifo.sv
      - verilog/cache_mesi_engine.sv
      - verilog/cache_lru_ranks.sv
      - verilog/cache_stats.sv
      - verilog/cache_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/cache_tb.sv

// ==== tests/cache_tb.sv ====
`include "cache_defs.svh"

module cache_tb
  import cache_cmd_pkg::*;
  import cache_line_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  typedef enum logic [1:0] {K_ADDR, K_CMD, K_READ} step_kind_e;

  typedef struct packed {
    step_kind_e  kind;
    logic [7:0]  off;
    logic [31:0] data;
    logic [31:0] rdata;  // Expected prdata on reads
    logic        err;    // Expected pslverr
    logic        burst;  // Access phase stays up for the next step
  } step_t;

  localparam int N_STEPS = 66;
  localparam int MAX_CYCLES = N_STEPS * (2 * `CACHE_FIFO_DEPTH + 12);

  // Address fields: tag is addr[31:10], set addr[9:6], offset addr[5:0]
  localparam step_t STEPS [N_STEPS] = '{
    '{K_ADDR, `REG_ADDR,   32'h0000_0444,      32'd0,             1'b0, 1'b0},  // Set 1 tag 1
    '{K_CMD,  `REG_CMD,    32'(CMD_READ),      32'd0,             1'b0, 1'b0},
    '{K_READ, `REG_PROBE,  32'd0,              32'(EXCLUSIVE),    1'b0, 1'b0},
    '{K_CMD,  `REG_CMD,    32'(CMD_READ),      32'd0,             1'b0, 1'b0},
    '{K_READ, `REG_PROBE,  32'd0,              32'(SHARED),       1'b0, 1'b0},
    '{K_READ, `REG_READS,  32'd0,              32'd2,             1'b0, 1'b0},
    '{K_READ, `REG_HITS,   32'd0,              32'd1,             1'b0, 1'b0},
    '{K_READ, `REG_MISSES, 32'd0,              32'd1,             1'b0, 1'b0},
    '{K_ADDR, `REG_ADDR,   32'h0000_0840,      32'd0,             1'b0, 1'b0},  // Set 1 tag 2
    '{K_CMD,  `REG_CMD,    32'(CMD_WRITE),     32'd0,             1'b0, 1'b0},
    '{K_READ, `REG_PROBE,  32'd0,              32'(MODIFIED),     1'b0, 1'b0},
    '{K_ADDR, `REG_ADDR,   32'h0000_0440,      32'd0,             1'b0, 1'b0},
    '{K_CMD,  `REG_CMD,    32'(CMD_WRITE),     32'd0,             1'b0, 1'b0},  // Hit on SHARED
    '{K_READ, `REG_PROBE,  32'd0,              32'(MODIFIED),     1'b0, 1'b0},
    '{K_READ, `REG_HITS,   32'd0,              32'd2,             1'b0, 1'b0},
    '{K_ADDR, `REG_ADDR,   32'h0000_0480,      32'd0,             1'b0, 1'b0},  // Set 2 fill
    '{K_CMD,  `REG_CMD,    32'(CMD_WRITE),     32'd0,             1'b0, 1'b0},
    '{K_ADDR, `REG_ADDR,   32'h0000_0880,      32'd0,             1'b0, 1'b0},
    '{K_CMD,  `REG_CMD,    32'(CMD_READ),      32'd0,             1'b0, 1'b0},
    '{K_ADDR, `REG_ADDR,   32'h0000_0C80,      32'd0,             1'b0, 1'b0},
    '{K_CMD,  `REG_CMD,    32'(CMD_READ),      32'd0,             1'b0, 1'b0},
    '{K_ADDR, `REG_ADDR,   32'h0000_1080,      32'd0,             1'b0, 1'b0},
    '{K_CMD,  `REG_CMD,    32'(CMD_READ),      32'd0,             1'b0, 1'b0},
    '{K_ADDR, `REG_ADDR,   32'h0000_1480,      32'd0,             1'b0, 1'b0},  // Fifth tag
    '{K_CMD,  `REG_CMD,    32'(CMD_READ),      32'd0,             1'b0, 1'b0},
    '{K_ADDR, `REG_ADDR,   32'h0000_04BC,      32'd0,             1'b0, 1'b0},  // First tag
    '{K_READ, `REG_PROBE,  32'd0,              32'(INVALID),      1'b0, 1'b0},
    '{K_READ, `REG_WBACKS, 32'd0,              32'd1,             1'b0, 1'b0},
    '{K_ADDR, `REG_ADDR,   32'h0000_0840,      32'd0,             1'b0, 1'b0},
    '{K_CMD,  `REG_CMD,    32'(CMD_INVAL),     32'd0,             1'b0, 1'b0},
    '{K_READ, `REG_PROBE,  32'd0,              32'(INVALID),      1'b0, 1'b0},
    '{K_READ, `REG_WBACKS, 32'd0,              32'd2,             1'b0, 1'b0},
    '{K_ADDR, `REG_ADDR,   32'h0000_1480,      32'd0,             1'b0, 1'b0},
    '{K_CMD,  `REG_CMD,    32'(CMD_SNOOP_RFO), 32'd0,             1'b0, 1'b0},
    '{K_READ, `REG_PROBE,  32'd0,              32'(INVALID),      1'b0, 1'b0},
    '{K_ADDR, `REG_ADDR,   32'h0000_7000,      32'd0,             1'b0, 1'b0},  // Never loaded
    '{K_CMD,  `REG_CMD,    32'(CMD_INVAL),     32'd0,             1'b0, 1'b0},
    '{K_CMD,  `REG_CMD,    32'(CMD_SNOOP_RFO), 32'd0,             1'b0, 1'b0},
    '{K_READ, `REG_HITS,   32'd0,              32'd2,             1'b0, 1'b0},
    '{K_READ, `REG_MISSES, 32'd0,              32'd7,             1'b0, 1'b0},
    '{K_READ, `REG_WBACKS, 32'd0,              32'd2,             1'b0, 1'b0},
    '{K_ADDR, `REG_ADDR,   32'h0000_0440,      32'd0,             1'b0, 1'b0},
    '{K_READ, `REG_ADDR,   32'd0,              32'h0000_0440,     1'b0, 1'b0},
    '{K_READ, `REG_PROBE,  32'd0,              32'(MODIFIED),     1'b0, 1'b0},
    '{K_CMD,  `REG_CMD,    32'(CMD_CLEAR),     32'd0,             1'b0, 1'b0},
    '{K_READ, `REG_PROBE,  32'd0,              32'(INVALID),      1'b0, 1'b0},
    '{K_ADDR, `REG_ADDR,   32'h0000_0880,      32'd0,             1'b0, 1'b0},
    '{K_READ, `REG_PROBE,  32'd0,              32'(INVALID),      1'b0, 1'b0},
    '{K_READ, `REG_READS,  32'd0,              32'd6,             1'b0, 1'b0},
    '{K_ADDR, `REG_ADDR,   32'h0000_04C0,      32'd0,             1'b0, 1'b0},  // Set 3 tag 1
    '{K_CMD,  `REG_CMD,    32'(CMD_READ),      32'd0,             1'b0, 1'b1},
    '{K_CMD,  `REG_CMD,    32'(CMD_READ),      32'd0,             1'b0, 1'b1},
    '{K_CMD,  `REG_CMD,    32'(CMD_WRITE),     32'd0,             1'b0, 1'b1},
    '{K_CMD,  `REG_CMD,    32'(CMD_READ),      32'd0,             1'b0, 1'b1},
    '{K_CMD,  `REG_CMD,    32'(CMD_READ),      32'd0,             1'b0, 1'b1},
    '{K_CMD,  `REG_CMD,    32'(CMD_WRITE),     32'd0,             1'b0, 1'b1},
    '{K_CMD,  `REG_CMD,    32'(CMD_READ),      32'd0,             1'b0, 1'b1},
    '{K_CMD,  `REG_CMD,    32'(CMD_WRITE),     32'd0,             1'b0, 1'b0},
    '{K_READ, `REG_PROBE,  32'd0,              32'(MODIFIED),     1'b0, 1'b0},
    '{K_CMD,  `REG_CMD,    32'd2,              32'd0,             1'b1, 1'b0},  // Reserved
    '{K_CMD,  `REG_CMD,    32'd9,              32'd0,             1'b1, 1'b0},
    '{K_CMD,  8'h24,       32'(CMD_READ),      32'd0,             1'b1, 1'b0},  // No register
    '{K_READ, `REG_READS,  32'd0,              32'd11,            1'b0, 1'b0},
    '{K_READ, `REG_WRITES, 32'd0,              32'd6,             1'b0, 1'b0},
    '{K_READ, `REG_HITS,   32'd0,              32'd9,             1'b0, 1'b0},
    '{K_READ, `REG_MISSES, 32'd0,              32'd8,             1'b0, 1'b0}
  };

  logic        Clock;
  logic        reset;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        in_burst;
  int          errors;
  int          checks;
  int          cycles;

  cache_top dut0 (
    .Clock(Clock), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  initial
  begin
    Clock = 1'b0;
    forever #20 Clock = ~Clock;
  end

  // pready is sampled mid-cycle, well clear of both edges
  task automatic wait_ready(output int waits);
    waits = 0;
    @(negedge Clock);
    while (!pready)
    begin
      waits++;
      @(negedge Clock);
    end
  endtask

  task automatic end_transfer(input logic keep);
    @(posedge Clock);
    #2;
    in_burst = keep;
    if (!keep)
    begin
      psel    = 1'b0;
      penable = 1'b0;
    end
  endtask

  // With a burst running the setup phase is skipped, one command per cycle
  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, input logic keep,
                           output logic err, output int waits);
    pwrite = 1'b1;
    paddr  = addr;
    pwdata = data;
    psel   = 1'b1;
    if (!in_burst)
    begin
      penable = 1'b0;
      @(posedge Clock);
      #2;
    end
    penable = 1'b1;
    wait_ready(waits);
    err = pslverr;
    end_transfer(keep);
  endtask

  task automatic read_reg(input logic [7:0] addr, output logic [31:0] data, output logic err);
    int waits;
    pwrite  = 1'b0;
    paddr   = addr;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge Clock);
    #2;
    penable = 1'b1;
    wait_ready(waits);
    data = prdata;
    err  = pslverr;
    end_transfer(1'b0);
  endtask

  initial
  begin
    logic [31:0] rdata;
    logic        err;
    logic        chained;
    int          waits;
    int          burst_waits;
    reset       = 1'b1;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    in_burst    = 1'b0;
    errors      = 0;
    checks      = 0;
    burst_waits = 0;
    repeat (3) @(posedge Clock);
    #2;
    reset = 1'b0;
    for (int i = 0; i < N_STEPS; i++)
    begin
      chained = in_burst;
      rdata   = '0;
      if (STEPS[i].kind == K_READ)
      begin
        read_reg(STEPS[i].off, rdata, err);
        checks++;
        if (rdata !== STEPS[i].rdata)
        begin
          errors++;
          $display("error at %0t ns: prdata expected %h, actual %h (step %0d)",
                   $time, STEPS[i].rdata, rdata, i);
        end
      end
      else
      begin
        write_reg(STEPS[i].off, STEPS[i].data, STEPS[i].burst, err, waits);
        burst_waits += waits;
        if (!chained)
        begin
          checks++;
          if (waits != 0)  // Queue has room, so no wait states
          begin
            errors++;
            $display("error at %0t ns: pready wait states expected 0, actual %0d (step %0d)",
                     $time, waits, i);
          end
        end
        if (chained && !STEPS[i].burst)
        begin
          checks++;
          if (burst_waits == 0)
          begin
            errors++;
            $display("Step %0d: the command burst never filled the queue and stalled pready", i);
          end
        end
        if (!STEPS[i].burst)
          burst_waits = 0;
      end
      checks++;
      if (err !== STEPS[i].err)
      begin
        errors++;
        $display("error at %0t ns: pslverr expected %b, actual %b (step %0d)",
                 $time, STEPS[i].err, err, i);
      end
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

  initial
  begin
    cycles = 0;
    while (cycles < MAX_CYCLES)
    begin
      @(posedge Clock);
      cycles++;
    end
    $display("Timeout: the table did not finish within %0d clock cycles", MAX_CYCLES);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// ==== verilog/cache_top.sv ====
`include "cache_defs.svh"

module cache_top
  import cache_cmd_pkg::*;
  import cache_line_pkg::*;
(
  input  logic        Clock,
  input  logic        reset,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  cache_req_t                      req;
  cache_req_t                      head;
  logic                            push;
  logic                            pop;
  logic                            full;
  logic                            empty;
  logic                            busy;
  mesi_e                           probe_state;
  logic                            touch;
  logic                            lru_clear;
  logic [`CACHE_SET_BITS-1:0]      lru_set;
  logic [`CACHE_WAY_BITS-1:0]      lru_way;
  logic [`CACHE_WAY_BITS-1:0]      victim;
  cache_event_t                    events;
  logic [4:0][`CACHE_CNT_BITS-1:0] counts;

  cache_apb_front front0 (
    .Clock(Clock), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .push(push), .req(req), .full(full), .busy(busy), .empty(empty),
    .probe_state(probe_state), .counts(counts)
  );

  cache_req_fifo fifo0 (
    .Clock(Clock), .reset(reset), .push(push), .pop(pop), .din(req), .dout(head),
    .full(full), .empty(empty)
  );

  cache_mesi_engine engine0 (
    .Clock(Clock), .reset(reset), .empty(empty), .head(head), .pop(pop), .busy(busy),
    .probe_addr(req.addr), .probe_state(probe_state), .touch(touch), .lru_clear(lru_clear),
    .lru_set(lru_set), .lru_way(lru_way), .victim(victim), .events(events)
  );

  cache_lru_ranks lru0 (
    .Clock(Clock), .reset(reset), .touch(touch), .clear(lru_clear), .set(lru_set),
    .way(lru_way), .victim(victim)
  );

  cache_stats stats0 (
    .Clock(Clock), .reset(reset), .events(events), .counts(counts)
  );

endmodule

// ==== verilog/cache_stats.sv ====
`include "cache_defs.svh"

module cache_stats
  import cache_line_pkg::*;
(
  input  logic                            Clock,
  input  logic                            reset,
  input  cache_event_t                    events,
  output logic [4:0][`CACHE_CNT_BITS-1:0] counts
);

  logic [4:0] flags;

  // Index order matches the register map: reads first, writebacks last
  assign flags = {events.wback, events.miss, events.hit, events.wr, events.rd};

  always_ff @(posedge Clock or posedge reset)
  begin
    if (reset)
      counts <= '0;
    else
    begin
      for (int i = 0; i < 5; i++)
      begin
        if (flags[i] && counts[i] != '1)  // Saturate at max
          counts[i] <= counts[i] + 1'b1;
      end
    end
  end

endmodule

// ==== verilog/cache_lru_ranks.sv ====
`include "cache_defs.svh"

module cache_lru_ranks (
  input  logic                       Clock,
  input  logic                       reset,
  input  logic                       touch,
  input  logic                       clear,
  input  logic [`CACHE_SET_BITS-1:0] set,
  input  logic [`CACHE_WAY_BITS-1:0] way,
  output logic [`CACHE_WAY_BITS-1:0] victim
);

  logic [`CACHE_WAY_BITS-1:0] ranks [`CACHE_SETS][`CACHE_WAYS];
  logic [`CACHE_WAY_BITS-1:0] old_rank;

  assign old_rank = ranks[set][way];

  always_comb
  begin
    victim = '0;
    for (int w = 0; w < `CACHE_WAYS; w++)
    begin
      if (ranks[set][w] == '0)  // Rank 0 is least recently used
        victim = w[`CACHE_WAY_BITS-1:0];
    end
  end

  always_ff @(posedge Clock or posedge reset)
  begin
    if (reset)
    begin
      for (int s = 0; s < `CACHE_SETS; s++)
        for (int w = 0; w < `CACHE_WAYS; w++)
          ranks[s][w] <= w[`CACHE_WAY_BITS-1:0];
    end
    else if (clear)
    begin
      for (int s = 0; s < `CACHE_SETS; s++)
        for (int w = 0; w < `CACHE_WAYS; w++)
          ranks[s][w] <= w[`CACHE_WAY_BITS-1:0];
    end
    else if (touch)
    begin
      for (int w = 0; w < `CACHE_WAYS; w++)
      begin
        if (w == way)
          ranks[set][w] <= '1;  // Top rank, WAYS-1
        else if (ranks[set][w] > old_rank)
          ranks[set][w] <= ranks[set][w] - 1'b1;
      end
    end
  end

endmodule

// ==== verilog/cache_mesi_engine.sv ====
`include "cache_defs.svh"

module cache_mesi_engine
  import cache_cmd_pkg::*;
  import cache_line_pkg::*;
(
  input  logic                       Clock,
  input  logic                       reset,
  input  logic                       empty,
  input  cache_req_t                 head,
  output logic                       pop,
  output logic                       busy,
  input  cache_addr_u                probe_addr,
  output mesi_e                      probe_state,
  output logic                       touch,
  output logic                       lru_clear,
  output logic [`CACHE_SET_BITS-1:0] lru_set,
  output logic [`CACHE_WAY_BITS-1:0] lru_way,
  input  logic [`CACHE_WAY_BITS-1:0] victim,
  output cache_event_t               events
);

  line_entry_t                lines [`CACHE_SETS][`CACHE_WAYS];
  cache_req_t                 req_q;
  logic                       hit_q;
  logic [`CACHE_WAY_BITS-1:0] way_q;
  logic [`CACHE_SET_BITS-1:0] set_q;
  logic [`CACHE_SET_BITS-1:0] head_set;
  logic [`CACHE_WAYS-1:0]     hit_vec;
  logic                       hit;
  logic [`CACHE_WAY_BITS-1:0] hit_way;
  logic                       has_free;
  logic [`CACHE_WAY_BITS-1:0] free_way;
  line_entry_t                cur;
  mesi_e                      next_state;

  assign pop      = !busy && !empty;
  assign head_set = head.addr.f.set;
  assign set_q    = req_q.addr.f.set;
  assign cur      = lines[set_q][way_q];
  assign lru_set  = busy ? set_q : head_set;  // Victim must be ready in the pop cycle
  assign lru_way  = way_q;

  // Downward scan so the lowest matching way wins
  always_comb
  begin
    hit_vec     = '0;
    hit         = 1'b0;
    hit_way     = '0;
    has_free    = 1'b0;
    free_way    = '0;
    probe_state = INVALID;
    for (int w = `CACHE_WAYS - 1; w >= 0; w--)
    begin
      if (lines[head_set][w].state != INVALID && lines[head_set][w].tag == head.addr.f.tag)
      begin
        hit_vec[w] = 1'b1;
        hit        = 1'b1;
        hit_way    = w[`CACHE_WAY_BITS-1:0];
      end
      if (lines[head_set][w].state == INVALID)
      begin
        has_free = 1'b1;
        free_way = w[`CACHE_WAY_BITS-1:0];
      end
      if (lines[probe_addr.f.set][w].state != INVALID &&
          lines[probe_addr.f.set][w].tag == probe_addr.f.tag)
        probe_state = lines[probe_addr.f.set][w].state;
    end
  end

  always_comb
  begin
    events     = '0;
    touch      = 1'b0;
    lru_clear  = 1'b0;
    next_state = INVALID;
    if (busy)
    begin
      case (req_q.cmd)
        CMD_READ, CMD_WRITE:
        begin
          events.rd    = (req_q.cmd == CMD_READ);
          events.wr    = (req_q.cmd == CMD_WRITE);
          events.hit   = hit_q;
          events.miss  = !hit_q;
          events.wback = !hit_q && cur.state == MODIFIED;  // Dirty victim evicted
          touch        = 1'b1;
          if (req_q.cmd == CMD_WRITE)
            next_state = MODIFIED;
          else if (!hit_q)
            next_state = EXCLUSIVE;
          else
            next_state = (cur.state == EXCLUSIVE) ? SHARED : cur.state;
        end
        CMD_INVAL:
        begin
          touch        = hit_q;
          events.wback = hit_q && cur.state == MODIFIED;
        end
        CMD_SNOOP_RFO: touch = hit_q;
        CMD_CLEAR:     lru_clear = 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge Clock)
  begin
    if (pop)
    begin
      req_q <= head;
      hit_q <= hit;
      way_q <= hit ? hit_way : (has_free ? free_way : victim);
    end
  end

  always_ff @(posedge Clock or posedge reset)
  begin
    if (reset)
      busy <= 1'b0;
    else
      busy <= pop;  // Update cycle follows every pop
  end

  always_ff @(posedge Clock or posedge reset)
  begin
    if (reset)
    begin
      for (int s = 0; s < `CACHE_SETS; s++)
        for (int w = 0; w < `CACHE_WAYS; w++)
          lines[s][w] <= '{tag: '0, state: INVALID};
    end
    else if (busy)
    begin
      case (req_q.cmd)
        CMD_READ, CMD_WRITE:
          lines[set_q][way_q] <= '{tag: req_q.addr.f.tag, state: next_state};
        CMD_INVAL, CMD_SNOOP_RFO:
          if (hit_q)
            lines[set_q][way_q].state <= INVALID;
        CMD_CLEAR:
          for (int s = 0; s < `CACHE_SETS; s++)
            for (int w = 0; w < `CACHE_WAYS; w++)
              lines[s][w].state <= INVALID;
        default: ;
      endcase
    end
  end

  a_single_hit: assert property (@(posedge Clock) disable iff (reset)
    pop |-> $onehot0(hit_vec));

endmodule

// ==== verilog/cache_req_fifo.sv ====
`include "cache_defs.svh"

module cache_req_fifo
  import cache_cmd_pkg::*;
(
  input  logic       Clock,
  input  logic       reset,
  input  logic       push,
  input  logic       pop,
  input  cache_req_t din,
  output cache_req_t dout,
  output logic       full,
  output logic       empty
);

  cache_req_t                           mem [`CACHE_FIFO_DEPTH];
  logic [$clog2(`CACHE_FIFO_DEPTH)-1:0] wr_ptr;
  logic [$clog2(`CACHE_FIFO_DEPTH)-1:0] rd_ptr;
  logic [$clog2(`CACHE_FIFO_DEPTH):0]   count;

  assign full  = (count == `CACHE_FIFO_DEPTH);
  assign empty = (count == 0);
  assign dout  = mem[rd_ptr];

  always_ff @(posedge Clock)
  begin
    if (push)
      mem[wr_ptr] <= din;
  end

  // Power of two depth so pointers wrap on their own
  always_ff @(posedge Clock or posedge reset)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  a_no_push_full: assert property (@(posedge Clock) disable iff (reset) push |-> !full);
  a_no_pop_empty: assert property (@(posedge Clock) disable iff (reset) pop |-> !empty);

endmodule

// ==== verilog/cache_apb_front.sv ====
`include "cache_defs.svh"

module cache_apb_front
  import cache_cmd_pkg::*;
  import cache_line_pkg::*;
(
  input  logic                               Clock,
  input  logic                               reset,
  input  logic                               psel,
  input  logic                               penable,
  input  logic                               pwrite,
  input  logic [7:0]                         paddr,
  input  logic [31:0]                        pwdata,
  output logic [31:0]                        prdata,
  output logic                               pready,
  output logic                               pslverr,
  output logic                               push,
  output cache_req_t                         req,
  input  logic                               full,
  input  logic                               busy,
  input  logic                               empty,
  input  mesi_e                              probe_state,
  input  logic [4:0][`CACHE_CNT_BITS-1:0]    counts
);

  cache_addr_u addr_q;
  logic        access;
  logic        cmd_ok;
  logic        idle;

  assign access = psel && penable;
  assign idle   = empty && !busy;  // All queued work has retired
  assign req.cmd  = cache_cmd_e'(pwdata[3:0]);
  assign req.addr = addr_q;

  always_comb
  begin
    case (pwdata[3:0])
      CMD_READ, CMD_WRITE, CMD_INVAL, CMD_SNOOP_RFO, CMD_CLEAR: cmd_ok = 1'b1;
      default: cmd_ok = 1'b0;
    endcase
  end

  always_comb
  begin
    pready  = 1'b0;
    pslverr = 1'b0;
    push    = 1'b0;
    prdata  = '0;
    if (access && pwrite)
    begin
      case (paddr)
        `REG_ADDR: pready = 1'b1;
        `REG_CMD:
        begin
          if (!cmd_ok)
          begin
            pready  = 1'b1;
            pslverr = 1'b1;
          end
          else if (!full)  // Otherwise wait for space
          begin
            pready = 1'b1;
            push   = 1'b1;
          end
        end
        default:
        begin
          pready  = 1'b1;
          pslverr = 1'b1;
        end
      endcase
    end
    else if (access && idle)
    begin
      pready = 1'b1;
      case (paddr)
        `REG_ADDR:   prdata = addr_q.raw;
        `REG_PROBE:  prdata = 32'(probe_state);
        `REG_READS:  prdata = 32'(counts[0]);
        `REG_WRITES: prdata = 32'(counts[1]);
        `REG_HITS:   prdata = 32'(counts[2]);
        `REG_MISSES: prdata = 32'(counts[3]);
        `REG_WBACKS: prdata = 32'(counts[4]);
        default:     pslverr = 1'b1;
      endcase
    end
  end

  always_ff @(posedge Clock or posedge reset)
  begin
    if (reset)
      addr_q <= '0;
    else if (access && pwrite && paddr == `REG_ADDR)
      addr_q <= pwdata;
  end

  a_penable_with_psel: assert property (@(posedge Clock) disable iff (reset)
    $rose(penable) |-> psel);

endmodule

// ==== verilog/cache_line_pkg.sv ====
`include "cache_defs.svh"

package cache_line_pkg;

  typedef enum logic [1:0] {
    MODIFIED  = 2'd0,
    EXCLUSIVE = 2'd1,
    SHARED    = 2'd2,
    INVALID   = 2'd3
  } mesi_e;

  typedef struct packed {
    logic [`CACHE_TAG_BITS-1:0] tag;
    mesi_e                      state;
  } line_entry_t;

  // One flag per counted event
  typedef struct packed {
    logic rd;
    logic wr;
    logic hit;
    logic miss;
    logic wback;
  } cache_event_t;

endpackage

// ==== verilog/cache_cmd_pkg.sv ====
`include "cache_defs.svh"

package cache_cmd_pkg;

  // Codes 2, 5-7 and 9-15 are reserved
  typedef enum logic [3:0] {
    CMD_READ      = 4'd0,
    CMD_WRITE     = 4'd1,
    CMD_INVAL     = 4'd3,  // Invalidate from L2
    CMD_SNOOP_RFO = 4'd4,  // Snooped read for ownership
    CMD_CLEAR     = 4'd8
  } cache_cmd_e;

  typedef struct packed {
    logic [`CACHE_TAG_BITS-1:0]    tag;
    logic [`CACHE_SET_BITS-1:0]    set;
    logic [`CACHE_OFFSET_BITS-1:0] offset;
  } addr_fields_t;

  // Same trace address seen raw or split into fields
  typedef union packed {
    logic [`CACHE_ADDR_BITS-1:0] raw;
    addr_fields_t                f;
  } cache_addr_u;

  typedef struct packed {
    cache_cmd_e  cmd;
    cache_addr_u addr;
  } cache_req_t;

endpackage

// ==== include/cache_defs.svh ====
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

`define CACHE_SETS        16
`define CACHE_WAYS        4
`define CACHE_LINE_BYTES  64
`define CACHE_ADDR_BITS   32
`define CACHE_CNT_BITS    16
`define CACHE_FIFO_DEPTH  4

`define CACHE_OFFSET_BITS ($clog2(`CACHE_LINE_BYTES))
`define CACHE_SET_BITS    ($clog2(`CACHE_SETS))
`define CACHE_WAY_BITS    ($clog2(`CACHE_WAYS))
`define CACHE_TAG_BITS    (`CACHE_ADDR_BITS - `CACHE_SET_BITS - `CACHE_OFFSET_BITS)

`define REG_ADDR    8'h00
`define REG_CMD     8'h04
`define REG_PROBE   8'h08
`define REG_READS   8'h10
`define REG_WRITES  8'h14
`define REG_HITS    8'h18
`define REG_MISSES  8'h1C
`define REG_WBACKS  8'h20

`endif
